/* rtl/plicPkg.sv */
`default_nettype none

package plicPkg;

  //////////////////////////////
  // sizes
  //////////////////////////////

  // sources 1..31, id 0 reserved for "no interrupt"
  localparam int numSrc    = 31;
  // machine and supervisor
  localparam int numCtx    = 2;
  localparam int prioWidth = 3;
  localparam int idWidth   = 5;

  typedef logic [31:0]          wordT;
  typedef logic [23:0]          addrT;
  typedef logic [prioWidth-1:0] prioT;
  typedef logic [idWidth-1:0]   srcIdT;
  typedef logic [31:0]          srcVecT;
  typedef logic [2:0]           regKindT;

  // bit 0 has no source behind it
  localparam srcVecT srcMask = 32'hFFFF_FFFE;

  // register kinds seen by the state and readback blocks
  localparam regKindT kindNone      = 3'd0;
  localparam regKindT kindPriority  = 3'd1;
  localparam regKindT kindPending   = 3'd2;
  localparam regKindT kindEnable    = 3'd3;
  localparam regKindT kindThreshold = 3'd4;
  localparam regKindT kindClaim     = 3'd5;

  //////////////////////////////
  // address map, byte offsets
  //////////////////////////////

  // priority n lives at addrPrioBase + 4*n
  localparam addrT addrPrioBase = 24'h000000;
  localparam addrT addrPending  = 24'h001000;
  localparam addrT addrEnable0  = 24'h002000;
  localparam addrT addrEnable1  = 24'h002080;
  localparam addrT addrThresh0  = 24'h200000;
  localparam addrT addrClaim0   = 24'h200004;
  localparam addrT addrThresh1  = 24'h201000;
  localparam addrT addrClaim1   = 24'h201004;

endpackage

`default_nettype wire

/* rtl/plicRegBus.sv */
`default_nettype none

// decoded register access, one per APB transfer
interface plicRegBus import plicPkg::*; ();

  // write strobe, access phase
  logic                          wrEn;
  // read strobe, setup phase
  logic                          rdEn;
  // which register family the offset hits
  regKindT                       kind;
  // 0 machine, 1 supervisor
  logic [$clog2(numCtx)-1:0]     ctx;
  // source index for priority accesses
  srcIdT                         srcIdx;
  wordT                          wrData;

  // address decoder side
  modport decode (
    output wrEn, rdEn, kind, ctx, srcIdx, wrData
  );

  // config registers and gateway
  modport state (
    input wrEn, rdEn, kind, ctx, srcIdx, wrData
  );

  // read data mux only cares about reads
  modport result (
    input rdEn, kind, ctx, srcIdx
  );

endinterface

`default_nettype wire

/* rtl/plicApbDecode.sv */
`default_nettype none

module plicApbDecode import plicPkg::*; (
  input  logic      PCLK,
  input  logic      PRESETn,
  input  logic      PSEL,
  input  logic      PENABLE,
  input  logic      PWRITE,
  input  addrT      PADDR,
  input  wordT      PWDATA,
  plicRegBus.decode bus
);

  logic                      setupPhase;
  logic                      accessPhase;
  logic                      rdStrobe;
  logic                      wrStrobe;
  regKindT                   kindDec;
  logic [$clog2(numCtx)-1:0] ctxDec;
  srcIdT                     srcDec;

  //////////////////////////////
  // phase detect
  //////////////////////////////

  assign setupPhase  = PSEL & ~PENABLE;
  assign accessPhase = PSEL & PENABLE;

  // read sampled early so PRDATA is ready for the access phase
  assign rdStrobe = setupPhase & ~PWRITE;
  // write lands on the edge closing the access phase
  assign wrStrobe = accessPhase & PWRITE;

  //////////////////////////////
  // offset match
  //////////////////////////////

  always_comb begin
    kindDec = kindNone;
    ctxDec  = '0;
    srcDec  = '0;
    if (PADDR[23:7] == addrPrioBase[23:7] && PADDR[1:0] == 2'b00) begin
      // word-aligned slot in the priority block
      kindDec = kindPriority;
      srcDec  = PADDR[6:2];
    end else begin
      case (PADDR)
        addrPending: kindDec = kindPending;
        addrEnable0: kindDec = kindEnable;
        addrEnable1: begin
          kindDec = kindEnable;
          ctxDec  = 1'b1;
        end
        addrThresh0: kindDec = kindThreshold;
        addrThresh1: begin
          kindDec = kindThreshold;
          ctxDec  = 1'b1;
        end
        addrClaim0:  kindDec = kindClaim;
        addrClaim1: begin
          kindDec = kindClaim;
          ctxDec  = 1'b1;
        end
        // anything else falls through as kindNone
        default: kindDec = kindNone;
      endcase
    end
  end

  assign bus.wrEn   = wrStrobe;
  assign bus.rdEn   = rdStrobe;
  assign bus.kind   = kindDec;
  assign bus.ctx    = ctxDec;
  assign bus.srcIdx = srcDec;
  assign bus.wrData = PWDATA;

  // a read strobe lasts one cycle and its transfer never turns into a write
  assert property (@(posedge PCLK) disable iff (!PRESETn)
    rdStrobe |=> !(rdStrobe || wrStrobe));

  // every access phase follows a setup phase of the same transfer
  assert property (@(posedge PCLK) disable iff (!PRESETn)
    accessPhase |-> $past(setupPhase));

endmodule

`default_nettype wire

/* rtl/plicConfigRegs.sv */
`default_nettype none

module plicConfigRegs import plicPkg::*; (
  input  logic              PCLK,
  input  logic              PRESETn,
  plicRegBus.state          bus,
  output prioT [numSrc:0]   prioVec,
  output srcVecT            enable0,
  output srcVecT            enable1,
  output prioT              thresh0,
  output prioT              thresh1
);

  // one priority per real source
  prioT [numSrc:1] prioReg;
  srcVecT          enReg0;
  srcVecT          enReg1;
  prioT            threshReg0;
  prioT            threshReg1;

  //////////////////////////////
  // register writes
  //////////////////////////////

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      prioReg    <= '0;
      enReg0     <= '0;
      enReg1     <= '0;
      threshReg0 <= '0;
      threshReg1 <= '0;
    end else if (bus.wrEn) begin
      case (bus.kind)
        kindPriority: begin
          // slot 0 is read-only zero
          if (bus.srcIdx != '0) prioReg[bus.srcIdx] <= bus.wrData[prioWidth-1:0];
        end
        kindEnable: begin
          if (bus.ctx != '0) enReg1 <= bus.wrData & srcMask;
          else               enReg0 <= bus.wrData & srcMask;
        end
        kindThreshold: begin
          if (bus.ctx != '0) threshReg1 <= bus.wrData[prioWidth-1:0];
          else               threshReg0 <= bus.wrData[prioWidth-1:0];
        end
        // pending is read-only, claim writes go to the gateway
        default: ;
      endcase
    end
  end

  // source 0 reads back as priority 0
  assign prioVec = {prioReg, prioT'(0)};
  assign enable0 = enReg0;
  assign enable1 = enReg1;
  assign thresh0 = threshReg0;
  assign thresh1 = threshReg1;

endmodule

`default_nettype wire

/* rtl/plicGateway.sv */
`default_nettype none

module plicGateway import plicPkg::*; (
  input  logic      PCLK,
  input  logic      PRESETn,
  input  srcVecT    irqSrc,
  plicRegBus.state  bus,
  input  srcIdT     claimId0,
  input  srcIdT     claimId1,
  output srcVecT    pending
);

  srcVecT pendReg;
  srcVecT inProgress;
  srcVecT nextPending;
  srcVecT claimSet;
  srcVecT completeClr;
  srcIdT  claimSel;
  logic   doClaim;
  logic   doComplete;

  //////////////////////////////
  // claim and complete
  //////////////////////////////

  // winner of the context being read
  assign claimSel = (bus.ctx != '0) ? claimId1 : claimId0;

  assign doClaim = bus.rdEn && bus.kind == kindClaim;

  // only ids 1..31 complete anything
  assign doComplete = bus.wrEn && bus.kind == kindClaim &&
                      bus.wrData[31:idWidth] == '0 && bus.wrData[idWidth-1:0] != '0;

  // claim of id 0 lands on bit 0 and is masked away
  assign claimSet    = doClaim ? ((srcVecT'(1) << claimSel) & srcMask) : '0;
  assign completeClr = doComplete ? (srcVecT'(1) << bus.wrData[idWidth-1:0]) : '0;

  // level sources latch until claimed, blocked while in service
  assign nextPending = (pendReg | irqSrc) & ~inProgress;

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      pendReg    <= '0;
      inProgress <= '0;
    end else begin
      pendReg    <= nextPending;
      inProgress <= (inProgress | claimSet) & ~completeClr;
    end
  end

  assign pending = pendReg;

  // a claim never hands out a source that is already in service
  assert property (@(posedge PCLK) disable iff (!PRESETn)
    (claimSet & inProgress) == '0);

endmodule

`default_nettype wire

/* rtl/plicArbiter.sv */
`default_nettype none

module plicArbiter import plicPkg::*; (
  input  prioT [numSrc:0] prioVec,
  input  srcVecT          pending,
  input  srcVecT          enable,
  input  prioT            threshold,
  output srcIdT           claimId,
  output logic            irq
);

  srcVecT active;
  prioT   maxPrio;
  srcIdT  bestId;

  //////////////////////////////
  // active set
  //////////////////////////////

  // pending and enabled for this context
  assign active = pending & enable & srcMask;

  // highest priority among active sources
  always_comb begin
    maxPrio = '0;
    for (int i = 1; i <= numSrc; i++) begin
      if (active[i] && prioVec[i] > maxPrio) begin
        maxPrio = prioVec[i];
      end
    end
  end

  //////////////////////////////
  // pick and compare
  //////////////////////////////

  // lowest id at that priority, scan downward so the last hit wins
  always_comb begin
    bestId = '0;
    // priority 0 never interrupts, leave id at 0
    if (maxPrio != '0) begin
      for (int i = numSrc; i >= 1; i--) begin
        if (active[i] && prioVec[i] == maxPrio) begin
          bestId = srcIdT'(i);
        end
      end
    end
  end

  assign claimId = bestId;

  // strictly above threshold, so threshold 7 masks everything
  assign irq = maxPrio > threshold;

  // a raised line always has a source to hand out
  always_comb begin
    assert (!irq || claimId != '0);
  end

endmodule

`default_nettype wire

/* rtl/plicReadback.sv */
`default_nettype none

module plicReadback import plicPkg::*; (
  input  logic            PCLK,
  input  logic            PRESETn,
  plicRegBus.result       bus,
  input  prioT [numSrc:0] prioVec,
  input  srcVecT          pending,
  input  srcVecT          enable0,
  input  srcVecT          enable1,
  input  prioT            thresh0,
  input  prioT            thresh1,
  input  srcIdT           claimId0,
  input  srcIdT           claimId1,
  output wordT            PRDATA
);

  wordT rdMux;
  wordT rdReg;
  logic ctxHi;

  assign ctxHi = bus.ctx != '0;

  //////////////////////////////
  // read select
  //////////////////////////////

  always_comb begin
    case (bus.kind)
      kindPriority:  rdMux = wordT'(prioVec[bus.srcIdx]);
      kindPending:   rdMux = pending;
      kindEnable:    rdMux = ctxHi ? enable1 : enable0;
      kindThreshold: rdMux = wordT'(ctxHi ? thresh1 : thresh0);
      // same id the gateway marks in progress at this edge
      kindClaim:     rdMux = wordT'(ctxHi ? claimId1 : claimId0);
      // unmapped offsets read as zero
      default:       rdMux = '0;
    endcase
  end

  // held through the access phase, zero between transfers
  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      rdReg <= '0;
    end else if (bus.rdEn) begin
      rdReg <= rdMux;
    end else begin
      rdReg <= '0;
    end
  end

  assign PRDATA = rdReg;

endmodule

`default_nettype wire

/* rtl/plicTop.sv */
`default_nettype none

module plicTop import plicPkg::*; (
  input  logic   PCLK,
  input  logic   PRESETn,
  input  logic   PSEL,
  input  logic   PENABLE,
  input  logic   PWRITE,
  input  addrT   PADDR,
  input  wordT   PWDATA,
  input  srcVecT irqSrc,
  output wordT   PRDATA,
  output logic   mExtInt,
  output logic   sExtInt
);

  prioT [numSrc:0] prioVec;
  srcVecT          enable0;
  srcVecT          enable1;
  prioT            thresh0;
  prioT            thresh1;
  srcVecT          pending;
  srcIdT           claimId0;
  srcIdT           claimId1;

  plicRegBus regBus ();

  //////////////////////////////
  // decode
  //////////////////////////////

  plicApbDecode u_decode (
    .PCLK(PCLK), .PRESETn(PRESETn), .PSEL(PSEL), .PENABLE(PENABLE),
    .PWRITE(PWRITE), .PADDR(PADDR), .PWDATA(PWDATA), .bus(regBus)
  );

  //////////////////////////////
  // state and arbitration
  //////////////////////////////

  plicConfigRegs u_config (
    .PCLK(PCLK), .PRESETn(PRESETn), .bus(regBus), .prioVec(prioVec),
    .enable0(enable0), .enable1(enable1), .thresh0(thresh0), .thresh1(thresh1)
  );

  // source 0 is tied off here
  plicGateway u_gateway (
    .PCLK(PCLK), .PRESETn(PRESETn), .irqSrc({irqSrc[numSrc:1], 1'b0}), .bus(regBus),
    .claimId0(claimId0), .claimId1(claimId1), .pending(pending)
  );

  // context 0, machine
  plicArbiter u_arb0 (
    .prioVec(prioVec), .pending(pending), .enable(enable0), .threshold(thresh0),
    .claimId(claimId0), .irq(mExtInt)
  );

  // context 1, supervisor
  plicArbiter u_arb1 (
    .prioVec(prioVec), .pending(pending), .enable(enable1), .threshold(thresh1),
    .claimId(claimId1), .irq(sExtInt)
  );

  plicReadback u_readback (
    .PCLK(PCLK), .PRESETn(PRESETn), .bus(regBus), .prioVec(prioVec), .pending(pending),
    .enable0(enable0), .enable1(enable1), .thresh0(thresh0), .thresh1(thresh1),
    .claimId0(claimId0), .claimId1(claimId1), .PRDATA(PRDATA)
  );

endmodule

`default_nettype wire

/* testbench/tbClock.sv */
`default_nettype none

module tbClock #(
  parameter int period      = 40,
  parameter int resetCycles = 8
) (
  output logic PCLK,
  output logic PRESETn
);

  // free-running APB clock
  initial begin
    PCLK = 1'b0;
    forever #(period / 2) PCLK = ~PCLK;
  end

  // reset held low for a fixed number of edges, released on a rising edge
  initial begin
    PRESETn = 1'b0;
    repeat (resetCycles) @(posedge PCLK);
    PRESETn <= 1'b1;
  end

endmodule

`default_nettype wire

/* testbench/plicTb.sv */
`default_nettype none

module plicTb import plicPkg::*; ();

  localparam int period   = 40;
  localparam int numTests = 6;

  logic   PCLK;
  logic   PRESETn;
  logic   PSEL;
  logic   PENABLE;
  logic   PWRITE;
  addrT   PADDR;
  wordT   PWDATA;
  srcVecT irqSrc;
  wordT   PRDATA;
  logic   mExtInt;
  logic   sExtInt;

  // reference model
  prioT   mPrio [0:numSrc];
  srcVecT mEn [0:numCtx-1];
  prioT   mThr [0:numCtx-1];
  srcVecT mPend;
  srcVecT mInProg;
  prioT   expPrio [0:numCtx-1];
  srcIdT  expId [0:numCtx-1];

  logic [31:0] rngState = 32'he9a8;
  string       testName = "none";
  int          errCount = 0;
  int          errAtStart = 0;
  int          testsRun = 0;
  int          testsFailed = 0;
  wordT        rd;

  tbClock #(.period(period), .resetCycles(8)) u_clk (.PCLK(PCLK), .PRESETn(PRESETn));

  plicTop u_dut (
    .PCLK(PCLK), .PRESETn(PRESETn), .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
    .PADDR(PADDR), .PWDATA(PWDATA), .irqSrc(irqSrc), .PRDATA(PRDATA),
    .mExtInt(mExtInt), .sExtInt(sExtInt)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic wordT nextRand();
    rngState = xorshift(rngState);
    return rngState;
  endfunction

  function automatic void mismatch(input string what, input wordT exp, input wordT act);
    $display("MISMATCH %s %s: expected %h, actual %h", testName, what, exp, act);
    errCount++;
  endfunction

  function automatic void expectWord(input string what, input wordT exp, input wordT act);
    if (act !== exp) mismatch(what, exp, act);
  endfunction

  // register view of the model, per the address map
  function automatic wordT modelRead(input addrT addr);
    wordT val;
    val = '0;
    if (addr < 24'h80 && addr[1:0] == 2'b00) val = wordT'(mPrio[addr[6:2]]);
    else if (addr == addrPending) val = mPend;
    else if (addr == addrEnable0) val = mEn[0];
    else if (addr == addrEnable1) val = mEn[1];
    else if (addr == addrThresh0) val = wordT'(mThr[0]);
    else if (addr == addrThresh1) val = wordT'(mThr[1]);
    else if (addr == addrClaim0) val = wordT'(expId[0]);
    else if (addr == addrClaim1) val = wordT'(expId[1]);
    return val;
  endfunction

  task automatic idle(input int n);
    repeat (n) @(posedge PCLK);
  endtask

  task automatic apbWrite(input addrT addr, input wordT data);
    PSEL    <= 1'b1;
    PENABLE <= 1'b0;
    PWRITE  <= 1'b1;
    PADDR   <= addr;
    PWDATA  <= data;
    @(posedge PCLK);
    PENABLE <= 1'b1;
    @(posedge PCLK);
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
    PWRITE  <= 1'b0;
  endtask

  task automatic apbRead(input addrT addr, output wordT data);
    wordT expData;
    PSEL    <= 1'b1;
    PENABLE <= 1'b0;
    PWRITE  <= 1'b0;
    PADDR   <= addr;
    // value the setup cycle should return
    @(negedge PCLK);
    expData = modelRead(addr);
    @(posedge PCLK);
    PENABLE <= 1'b1;
    // PRDATA is stable mid access phase
    @(negedge PCLK);
    data = PRDATA;
    expectWord($sformatf("read %h", addr), expData, data);
    @(posedge PCLK);
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
  endtask

  task automatic checkLines(input logic expM, input logic expS);
    @(negedge PCLK);
    expectWord("mExtInt", wordT'(expM), wordT'(mExtInt));
    expectWord("sExtInt", wordT'(expS), wordT'(sExtInt));
    @(posedge PCLK);
  endtask

  task automatic startTest(input string name);
    testName   = name;
    errAtStart = errCount;
  endtask

  task automatic endTest();
    testsRun++;
    if (errCount != errAtStart) testsFailed++;
    $display("test %-10s %s", testName, (errCount == errAtStart) ? "passed" : "failed");
  endtask

  //////////////////////////////
  // model
  //////////////////////////////

  always @(posedge PCLK) begin : modelUpdate
    srcVecT nextInProg;
    logic   ctxHi;
    nextInProg = mInProg;
    ctxHi      = (PADDR == addrClaim1);
    if (!PRESETn) begin
      for (int i = 0; i <= numSrc; i++) begin
        mPrio[i] <= '0;
      end
      mEn[0]  <= '0;
      mEn[1]  <= '0;
      mThr[0] <= '0;
      mThr[1] <= '0;
      mPend   <= '0;
      mInProg <= '0;
    end else begin
      // level requests latch unless the source is in service
      mPend <= (mPend | (irqSrc & srcMask)) & ~mInProg;
      // claim read in its setup phase
      if (PSEL && !PENABLE && !PWRITE && (PADDR == addrClaim0 || ctxHi)) begin
        nextInProg = nextInProg | ((srcVecT'(1) << expId[ctxHi]) & srcMask);
      end
      // writes land at the end of the access phase
      if (PSEL && PENABLE && PWRITE) begin
        if (PADDR < 24'h80 && PADDR[1:0] == 2'b00 && PADDR[6:2] != 5'd0) begin
          mPrio[PADDR[6:2]] <= PWDATA[2:0];
        end
        case (PADDR)
          addrEnable0: mEn[0] <= PWDATA & srcMask;
          addrEnable1: mEn[1] <= PWDATA & srcMask;
          addrThresh0: mThr[0] <= PWDATA[2:0];
          addrThresh1: mThr[1] <= PWDATA[2:0];
          addrClaim0, addrClaim1: begin
            if (PWDATA >= 32'd1 && PWDATA <= 32'd31) nextInProg[PWDATA[4:0]] = 1'b0;
          end
          default: ;
        endcase
      end
      mInProg <= nextInProg;
    end
  end

  // most urgent active source per context
  always_comb begin
    for (int c = 0; c < numCtx; c++) begin
      expPrio[c] = '0;
      expId[c]   = '0;
      // upward scan with strict compare keeps the lowest id on a tie
      for (int i = 1; i <= numSrc; i++) begin
        if (mPend[i] && mEn[c][i] && mPrio[i] > expPrio[c]) begin
          expPrio[c] = mPrio[i];
          expId[c]   = srcIdT'(i);
        end
      end
    end
  end

  // interrupt lines follow the model every cycle
  assert property (@(posedge PCLK) disable iff (!PRESETn) mExtInt == (expPrio[0] > mThr[0]))
    else mismatch("mExtInt", wordT'($sampled(expPrio[0] > mThr[0])), wordT'($sampled(mExtInt)));
  assert property (@(posedge PCLK) disable iff (!PRESETn) sExtInt == (expPrio[1] > mThr[1]))
    else mismatch("sExtInt", wordT'($sampled(expPrio[1] > mThr[1])), wordT'($sampled(sExtInt)));

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin : stimulus
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
    PADDR   = '0;
    PWDATA  = '0;
    irqSrc  = '0;
    wait (PRESETn === 1'b1);
    @(posedge PCLK);

    // everything reads zero out of reset
    startTest("reset");
    @(negedge PCLK);
    expectWord("PRDATA", '0, PRDATA);
    @(posedge PCLK);
    checkLines(1'b0, 1'b0);
    for (int n = 0; n <= numSrc; n++) apbRead(addrPrioBase + addrT'(4 * n), rd);
    apbRead(addrPending, rd);
    apbRead(addrEnable0, rd);
    apbRead(addrEnable1, rd);
    apbRead(addrThresh0, rd);
    apbRead(addrThresh1, rd);
    apbRead(addrClaim0, rd);
    apbRead(addrClaim1, rd);
    // unmapped offset
    apbRead(24'h003000, rd);
    endTest();

    // write random words, read back masked
    startTest("regs");
    for (int n = 0; n <= numSrc; n++) apbWrite(addrPrioBase + addrT'(4 * n), nextRand());
    apbWrite(addrEnable0, nextRand());
    apbWrite(addrEnable1, nextRand());
    apbWrite(addrThresh0, nextRand());
    apbWrite(addrThresh1, nextRand());
    for (int n = 0; n <= numSrc; n++) apbRead(addrPrioBase + addrT'(4 * n), rd);
    apbRead(addrEnable0, rd);
    apbRead(addrEnable1, rd);
    apbRead(addrThresh0, rd);
    apbRead(addrThresh1, rd);
    endTest();

    // random rounds, the last with nothing enabled
    startTest("arbiter");
    for (int r = 0; r < 5; r++) begin
      for (int n = 1; n <= numSrc; n++) apbWrite(addrT'(4 * n), nextRand());
      apbWrite(addrEnable0, (r == 4) ? 32'd0 : nextRand());
      apbWrite(addrEnable1, (r == 4) ? 32'd0 : nextRand());
      apbWrite(addrThresh0, 32'd0);
      apbWrite(addrThresh1, 32'd0);
      irqSrc <= nextRand();
      idle(2);
      apbRead(addrClaim0, rd);
      apbWrite(addrClaim0, rd);
      apbRead(addrClaim1, rd);
      apbWrite(addrClaim1, rd);
    end
    endTest();

    // sweep thresholds over a priority 7 source
    startTest("threshold");
    apbWrite(addrT'(4 * 5), 32'd7);
    apbWrite(addrEnable0, 32'h20);
    apbWrite(addrEnable1, 32'h20);
    irqSrc <= 32'h20;
    for (int t = 0; t < 8; t++) begin
      apbWrite(addrThresh0, wordT'(t));
      apbWrite(addrThresh1, wordT'(7 - t));
      idle(1);
    end
    checkLines(1'b0, 1'b1);
    apbWrite(addrThresh1, 32'd7);
    checkLines(1'b0, 1'b0);
    endTest();

    // sources 3 and 9 tie at 5, 12 trails at 2
    startTest("claim");
    apbWrite(addrT'(4 * 3), 32'd5);
    apbWrite(addrT'(4 * 9), 32'd5);
    apbWrite(addrT'(4 * 12), 32'd2);
    apbWrite(addrEnable0, 32'h1208);
    apbWrite(addrThresh0, 32'd0);
    irqSrc <= 32'h1208;
    idle(2);
    apbRead(addrClaim0, rd);
    expectWord("first claim", 32'd3, rd);
    apbRead(addrPending, rd);
    expectWord("pending 3 after claim", 32'd0, wordT'(rd[3]));
    apbRead(addrClaim0, rd);
    expectWord("second claim", 32'd9, rd);
    apbWrite(addrClaim0, 32'd3);
    idle(1);
    apbRead(addrPending, rd);
    expectWord("pending 3 after complete", 32'd1, wordT'(rd[3]));
    apbWrite(addrClaim0, 32'd9);
    endTest();

    // source 20 in one context at a time
    startTest("context");
    apbWrite(addrT'(4 * 20), 32'd4);
    apbWrite(addrEnable0, 32'd0);
    apbWrite(addrEnable1, 32'h0010_0000);
    apbWrite(addrThresh1, 32'd0);
    irqSrc <= 32'h0010_0000;
    idle(2);
    checkLines(1'b0, 1'b1);
    apbRead(addrClaim0, rd);
    expectWord("machine claim", 32'd0, rd);
    apbRead(addrClaim1, rd);
    expectWord("supervisor claim", 32'd20, rd);
    apbWrite(addrClaim1, 32'd20);
    apbWrite(addrEnable1, 32'd0);
    apbWrite(addrEnable0, 32'h0010_0000);
    idle(2);
    checkLines(1'b1, 1'b0);
    apbRead(addrClaim0, rd);
    expectWord("machine claim", 32'd20, rd);
    apbWrite(addrClaim0, 32'd20);
    endTest();

    $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errCount);
    if (errCount == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // generous bound, 400 cycles per test
  initial begin : watchdog
    #(numTests * 400 * period);
    $display("timeout: tests did not finish within %0d cycles", numTests * 400);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
rtl/plicPkg.sv
rtl/plicRegBus.sv
rtl/plicApbDecode.sv
rtl/plicConfigRegs.sv
rtl/plicGateway.sv
rtl/plicArbiter.sv
rtl/plicReadback.sv
rtl/plicTop.sv
testbench/tbClock.sv
testbench/plicTb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the PLIC testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module plicTb -f src.f -o plicSim

./obj_dir/plicSim | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi

if ! grep -q "STATUS: PASS" sim.log; then
  exit 1
fi

exit 0
